/* design/lsu_isa_pkg.sv */
// --------------------------------------------------------------------------
// instruction set view of the load/store unit, 32-bit data only
// bit 2 of a format marks an unsigned load, the low two bits are the size
// --------------------------------------------------------------------------
package lsu_isa_pkg;

    localparam int xlen    = 32;
    localparam int nr_bits = 5;

    // load/store formats
    typedef enum logic [2:0] {
        fmt_b  = 3'b000,
        fmt_h  = 3'b001,
        fmt_w  = 3'b010,
        fmt_bu = 3'b100,
        fmt_hu = 3'b101
    } lsu_fmt_e;

    // access sizes, as coded in the low format bits
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } lsu_size_e;

    typedef logic [nr_bits-1:0] reg_idx_t;

    function automatic lsu_size_e lsu_size(input lsu_fmt_e fmt);
        lsu_size_e size;
        size = lsu_size_e'(fmt[1:0]);
        return size;
    endfunction

endpackage

/* design/lsu_pkg.sv */
// --------------------------------------------------------------------------
// load/store slice traffic: four lanes of one word each
// the memory tag carries everything needed to finish a load on return
// --------------------------------------------------------------------------
package lsu_pkg;

    import lsu_isa_pkg::*;

    localparam int num_lanes  = 4;
    localparam int word_size  = 4;
    localparam int align_bits = 2;
    localparam int mem_addr_w = 30;
    localparam int nw_width   = 2;
    localparam int pc_bits    = 30;
    localparam int uuid_width = 8;

    typedef logic [num_lanes-1:0] lane_mask_t;
    typedef logic [num_lanes-1:0][xlen-1:0] lane_data_t;
    typedef logic [num_lanes-1:0][align_bits-1:0] lane_align_t;

    // execute packet
    typedef struct packed {
        logic [uuid_width-1:0] uuid;
        logic [nw_width-1:0]   wid;
        lane_mask_t            tmask;
        logic [pc_bits-1:0]    pc;
        reg_idx_t              rd;
        logic                  wb;
        logic                  is_store;
        lsu_fmt_e              fmt;
        logic [11:0]           offset;
        lane_data_t            rs1_data;
        lane_data_t            rs2_data;
    } exec_req_t;

    typedef struct packed {
        logic [uuid_width-1:0] uuid;
        logic [nw_width-1:0]   wid;
        logic [pc_bits-1:0]    pc;
        logic                  wb;
        reg_idx_t              rd;
        lsu_fmt_e              fmt;
        lane_align_t           align;
    } lsu_tag_t;

    typedef struct packed {
        logic                                      rw;
        lane_mask_t                                mask;
        logic [num_lanes-1:0][word_size-1:0]       byteen;
        logic [num_lanes-1:0][mem_addr_w-1:0]      addr;
        lane_data_t                                data;
        lsu_tag_t                                  tag;
    } mem_req_t;

    typedef struct packed {
        lane_mask_t mask;
        lane_data_t data;
        lsu_tag_t   tag;
    } mem_rsp_t;

    typedef struct packed {
        logic [uuid_width-1:0] uuid;
        logic [nw_width-1:0]   wid;
        lane_mask_t            tmask;
        logic [pc_bits-1:0]    pc;
        logic                  wb;
        reg_idx_t              rd;
        lane_data_t            data;
    } commit_t;

endpackage

/* design/lsu_req_format.sv */
// --------------------------------------------------------------------------
// turns an execute packet into one memory request for all lanes
// misaligned accesses are not supported and are flagged in simulation
// --------------------------------------------------------------------------
module lsu_req_format import lsu_isa_pkg::*, lsu_pkg::*; (
    input  logic      clk,
    input  logic      exec_fire,
    input  exec_req_t exec_data,
    output mem_req_t  mem_req
);

    lsu_size_e                          wsize;
    logic [num_lanes-1:0][xlen-1:0]     full_addr;
    lane_align_t                        req_align;
    logic [num_lanes-1:0][word_size-1:0] req_byteen;
    lane_data_t                         req_data;
    lane_mask_t                         lane_misaligned;

    assign wsize = lsu_size(exec_data.fmt);

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        logic [word_size-1:0] byteen;

        // base plus sign-extended offset
        assign full_addr[i] = exec_data.rs1_data[i] + xlen'(signed'(exec_data.offset));
        assign req_align[i] = full_addr[i][align_bits-1:0];

        always_comb begin
            case (wsize)
                size_byte: byteen = word_size'(1) << req_align[i];
                size_half: byteen = word_size'(2'b11) << {req_align[i][1], 1'b0};
                default:   byteen = '1;
            endcase
        end

        assign req_byteen[i] = byteen;

        // move the store bytes into their lanes of the word
        assign req_data[i] = exec_data.rs2_data[i] << {req_align[i], 3'b000};

        assign lane_misaligned[i] = (wsize == size_half && req_align[i][0])
                                 || (wsize == size_word && req_align[i] != '0);

        assert property (@(posedge clk) exec_fire && exec_data.tmask[i] |-> !lane_misaligned[i]);
    end

    always_comb begin
        mem_req.rw     = exec_data.is_store;
        mem_req.mask   = exec_data.tmask;
        mem_req.byteen = req_byteen;
        for (int i = 0; i < num_lanes; i++) begin
            mem_req.addr[i] = full_addr[i][xlen-1:align_bits];
        end
        mem_req.data   = req_data;

        // tag comes back unchanged with a load response
        mem_req.tag.uuid  = exec_data.uuid;
        mem_req.tag.wid   = exec_data.wid;
        mem_req.tag.pc    = exec_data.pc;
        mem_req.tag.wb    = exec_data.wb;
        mem_req.tag.rd    = exec_data.rd;
        mem_req.tag.fmt   = exec_data.fmt;
        mem_req.tag.align = req_align;
    end

endmodule

/* design/lsu_rsp_format.sv */
// --------------------------------------------------------------------------
// load response alignment and extension, purely combinational
// lanes outside the response mask carry don't-care data
// --------------------------------------------------------------------------
module lsu_rsp_format import lsu_isa_pkg::*, lsu_pkg::*; (
    input  mem_rsp_t mem_rsp,
    output commit_t  rsp_commit
);

    lsu_tag_t   tag;
    lane_data_t rsp_data;

    assign tag = mem_rsp.tag;

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        logic [15:0]     half_sel;
        logic [7:0]      byte_sel;
        logic [xlen-1:0] lane_data;

        // half first, then byte within it
        assign half_sel = tag.align[i][1] ? mem_rsp.data[i][31:16] : mem_rsp.data[i][15:0];
        assign byte_sel = tag.align[i][0] ? half_sel[15:8] : half_sel[7:0];

        always_comb begin
            case (tag.fmt)
                fmt_b:   lane_data = xlen'(signed'(byte_sel));
                fmt_h:   lane_data = xlen'(signed'(half_sel));
                fmt_bu:  lane_data = xlen'(byte_sel);
                fmt_hu:  lane_data = xlen'(half_sel);
                default: lane_data = mem_rsp.data[i];
            endcase
        end

        assign rsp_data[i] = lane_data;
    end

    always_comb begin
        rsp_commit.uuid  = tag.uuid;
        rsp_commit.wid   = tag.wid;
        rsp_commit.tmask = mem_rsp.mask;
        rsp_commit.pc    = tag.pc;
        rsp_commit.wb    = tag.wb;
        rsp_commit.rd    = tag.rd;
        rsp_commit.data  = rsp_data;
    end

endmodule

/* design/lsu_elastic_buf.sv */
// --------------------------------------------------------------------------
// two-entry skid buffer, output always comes from a register
// ready_in is registered and only low with both entries held
// --------------------------------------------------------------------------
module lsu_elastic_buf #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     valid_in,
    output logic     ready_in,
    input  payload_t data_in,
    output logic     valid_out,
    input  logic     ready_out,
    output payload_t data_out
);

    logic     out_valid;
    logic     skid_valid;
    payload_t out_data;
    payload_t skid_data;
    logic     in_fire;
    logic     out_load;

    assign ready_in = ~skid_valid;
    assign in_fire  = valid_in && ready_in;
    // output register is free or emptying this cycle
    assign out_load = ~out_valid || ready_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_load) begin
            out_valid  <= skid_valid || valid_in;
            skid_valid <= 1'b0;
        end else if (in_fire) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_load) begin
            out_data <= skid_valid ? skid_data : data_in;
        end else if (in_fire) begin
            skid_data <= data_in;
        end
    end

    assign valid_out = out_valid;
    assign data_out  = out_data;

    // full and stalled, both held entries stay untouched
    assert property (@(posedge clk) disable iff (reset)
        out_valid && skid_valid && !ready_out
        |=> skid_valid && $stable(skid_data) && $stable(out_data));

endmodule

/* design/lsu_commit_arb.sv */
// --------------------------------------------------------------------------
// fixed priority, input 0 always wins when valid
// one registered output stage which holds under back-pressure
// --------------------------------------------------------------------------
module lsu_commit_arb import lsu_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic [1:0]    valid_in,
    output logic [1:0]    ready_in,
    input  commit_t [1:0] data_in,
    output logic          valid_out,
    input  logic          ready_out,
    output commit_t       data_out
);

    logic    out_valid;
    commit_t out_data;
    logic    out_load;
    commit_t grant_data;

    assign out_load = ~out_valid || ready_out;

    // input 1 only when input 0 is idle
    assign ready_in[0] = out_load;
    assign ready_in[1] = out_load && ~valid_in[0];

    assign grant_data = valid_in[0] ? data_in[0] : data_in[1];

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (out_load) begin
            out_valid <= |valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (out_load && |valid_in) begin
            out_data <= grant_data;
        end
    end

    assign valid_out = out_valid;
    assign data_out  = out_data;

    assert property (@(posedge clk) disable iff (reset)
        valid_out && !ready_out |=> valid_out && $stable(data_out));

endmodule

/* design/lsu_slice.sv */
// --------------------------------------------------------------------------
// load/store slice: one memory request per warp instruction
// loads may return out of order, stores commit without a memory response
// --------------------------------------------------------------------------
module lsu_slice import lsu_pkg::*; (
    input  logic      clk,
    input  logic      reset,

    input  logic      exec_valid,
    output logic      exec_ready,
    input  exec_req_t exec_data,

    output logic      mem_req_valid,
    input  logic      mem_req_ready,
    output mem_req_t  mem_req,

    input  logic      mem_rsp_valid,
    output logic      mem_rsp_ready,
    input  mem_rsp_t  mem_rsp,

    output logic      commit_valid,
    input  logic      commit_ready,
    output commit_t   commit
);

    logic    is_store;
    logic    store_blocked;
    logic    exec_fire;
    logic    no_rsp_valid_in;
    logic    no_rsp_ready_in;
    commit_t store_commit;
    commit_t rsp_commit;

    logic    rsp_buf_valid;
    logic    rsp_buf_ready;
    commit_t rsp_buf_data;
    logic    no_rsp_buf_valid;
    logic    no_rsp_buf_ready;
    commit_t no_rsp_buf_data;

    assign is_store      = exec_data.is_store;
    // a store may only go out when its commit slot is free
    assign store_blocked = is_store && ~no_rsp_ready_in;

    assign mem_req_valid   = exec_valid && ~store_blocked;
    assign exec_ready      = mem_req_ready && ~store_blocked;
    assign exec_fire       = exec_valid && exec_ready;
    assign no_rsp_valid_in = exec_valid && is_store && mem_req_ready;

    always_comb begin
        store_commit       = '0;
        store_commit.uuid  = exec_data.uuid;
        store_commit.wid   = exec_data.wid;
        store_commit.tmask = exec_data.tmask;
        store_commit.pc    = exec_data.pc;
    end

    lsu_req_format i_req_format (
        .clk       (clk),
        .exec_fire (exec_fire),
        .exec_data (exec_data),
        .mem_req   (mem_req)
    );

    lsu_rsp_format i_rsp_format (
        .mem_rsp    (mem_rsp),
        .rsp_commit (rsp_commit)
    );

    lsu_elastic_buf #(
        .payload_t (commit_t)
    ) rsp_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (mem_rsp_valid),
        .ready_in  (mem_rsp_ready),
        .data_in   (rsp_commit),
        .valid_out (rsp_buf_valid),
        .ready_out (rsp_buf_ready),
        .data_out  (rsp_buf_data)
    );

    lsu_elastic_buf #(
        .payload_t (commit_t)
    ) no_rsp_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (no_rsp_valid_in),
        .ready_in  (no_rsp_ready_in),
        .data_in   (store_commit),
        .valid_out (no_rsp_buf_valid),
        .ready_out (no_rsp_buf_ready),
        .data_out  (no_rsp_buf_data)
    );

    // load responses take priority over store commits
    lsu_commit_arb i_commit_arb (
        .clk       (clk),
        .reset     (reset),
        .valid_in  ({no_rsp_buf_valid, rsp_buf_valid}),
        .ready_in  ({no_rsp_buf_ready, rsp_buf_ready}),
        .data_in   ({no_rsp_buf_data, rsp_buf_data}),
        .valid_out (commit_valid),
        .ready_out (commit_ready),
        .data_out  (commit)
    );

endmodule

/* verif/lsu_tb.sv */
// ---------------------------------------------------------------------------
// random loads and stores into lsu_slice, memory answers loads out of order
// memory words are a fixed function of the address, store data is not kept
// ---------------------------------------------------------------------------
module lsu_tb import lsu_isa_pkg::*, lsu_pkg::*; ();

    localparam int num_instr      = 200;
    localparam int timeout_cycles = num_instr * 60;

    logic      clk;
    logic      reset;
    logic      exec_valid;
    logic      exec_ready;
    exec_req_t exec_data;
    logic      mem_req_valid;
    logic      mem_req_ready = 1'b0;
    mem_req_t  mem_req;
    logic      mem_rsp_valid = 1'b0;
    logic      mem_rsp_ready;
    mem_rsp_t  mem_rsp = '0;
    logic      commit_valid;
    logic      commit_ready = 1'b0;
    commit_t   commit;

    // next falling-edge values, worked out by the monitor
    logic      next_req_ready = 1'b0;
    logic      next_commit_ready = 1'b0;
    logic      next_rsp_valid = 1'b0;
    mem_rsp_t  next_rsp = '0;

    exec_req_t stim [num_instr];
    commit_t   expected [logic [7:0]];
    logic      expected_store [logic [7:0]];
    mem_rsp_t  pend_rsp [$];
    int        pend_due [$];
    int        cycle = 0;
    int        commits = 0;
    int        accepted = 0;
    int        stores_seen = 0;
    int        check_errors = 0;
    int        other_errors = 0;
    int        drain_errors = 0;
    logic      after_reset = 1'b1;

    lsu_slice i_lsu_slice (
        .clk           (clk),
        .reset         (reset),
        .exec_valid    (exec_valid),
        .exec_ready    (exec_ready),
        .exec_data     (exec_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .mem_rsp       (mem_rsp),
        .commit_valid  (commit_valid),
        .commit_ready  (commit_ready),
        .commit        (commit)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] mem_word(input logic [29:0] waddr);
        logic [31:0] w;
        w = {2'b00, waddr};
        return {w[28:0], w[31:29]} ^ 32'h5a5a5a5a;
    endfunction

    function automatic lsu_fmt_e pick_fmt(input int k);
        case (k)
            0:       return fmt_b;
            1:       return fmt_h;
            2:       return fmt_w;
            3:       return fmt_bu;
            default: return fmt_hu;
        endcase
    endfunction

    function automatic logic align_legal(input lsu_fmt_e fmt, input int a);
        return (fmt[1:0] == 2'd0) || (fmt[1:0] == 2'd1 && a % 2 == 0) || (a == 0);
    endfunction

    // align below zero picks a random legal alignment per lane
    function automatic exec_req_t make_instr(input int n, input logic store,
                                             input lsu_fmt_e fmt, input int align);
        exec_req_t   e;
        logic [31:0] target;
        logic [1:0]  al;
        e.uuid     = 8'(n);
        e.wid      = 2'($urandom);
        e.tmask    = (align >= 0) ? 4'hf : 4'($urandom_range(15, 1));
        e.pc       = 30'($urandom);
        e.rd       = 5'($urandom);
        e.wb       = store ? 1'($urandom) : 1'b1;
        e.is_store = store;
        e.fmt      = fmt;
        e.offset   = 12'($urandom);
        for (int i = 0; i < num_lanes; i++) begin
            al = (align >= 0) ? 2'(align) : 2'($urandom);
            if (fmt[1:0] == 2'd1) al[0] = 1'b0;
            else if (fmt[1:0] == 2'd2) al = 2'b00;
            target = $urandom;
            target[1:0] = al;
            e.rs1_data[i] = target - {{20{e.offset[11]}}, e.offset};
            e.rs2_data[i] = $urandom;
        end
        return e;
    endfunction

    task automatic build_stimulus();
        int n;
        lsu_fmt_e fmt;
        n = 0;
        // every format at every legal alignment first
        for (int s = 0; s < 2; s++) begin
            for (int f = 0; f < 5; f++) begin
                for (int a = 0; a < 4; a++) begin
                    fmt = pick_fmt(f);
                    if ((s == 1 && fmt[2]) || !align_legal(fmt, a)) continue;
                    stim[n] = make_instr(n, s == 1, fmt, a);
                    n++;
                end
            end
        end
        while (n < num_instr) begin
            if ($urandom_range(1, 0) == 1) begin
                stim[n] = make_instr(n, 1'b1, pick_fmt($urandom_range(2, 0)), -1);
            end else begin
                stim[n] = make_instr(n, 1'b0, pick_fmt($urandom_range(4, 0)), -1);
            end
            n++;
        end
    endtask

    function automatic void expected_results(input exec_req_t e, output mem_req_t req,
                                             output commit_t cmt);
        logic [31:0] full;
        logic [1:0]  al;
        logic [31:0] word;
        logic [31:0] moved;
        req = '0;
        cmt = '0;
        req.rw = e.is_store;
        req.mask = e.tmask;
        req.tag.uuid = e.uuid;
        req.tag.wid = e.wid;
        req.tag.pc = e.pc;
        req.tag.wb = e.wb;
        req.tag.rd = e.rd;
        req.tag.fmt = e.fmt;
        cmt.uuid = e.uuid;
        cmt.wid = e.wid;
        cmt.tmask = e.tmask;
        cmt.pc = e.pc;
        cmt.wb = e.is_store ? 1'b0 : e.wb;
        cmt.rd = e.is_store ? '0 : e.rd;
        for (int i = 0; i < num_lanes; i++) begin
            full = e.rs1_data[i] + {{20{e.offset[11]}}, e.offset};
            al = full[1:0];
            req.addr[i] = full[31:2];
            req.tag.align[i] = al;
            for (int b = 0; b < 4; b++) begin
                case (e.fmt[1:0])
                    2'd0:    req.byteen[i][b] = (b == int'(al));
                    2'd1:    req.byteen[i][b] = (b / 2 == int'(al) / 2);
                    default: req.byteen[i][b] = 1'b1;
                endcase
            end
            req.data[i] = e.rs2_data[i] << (8 * al);
            word = mem_word(full[31:2]);
            moved = word >> (8 * al);
            if (!e.is_store) begin
                case (e.fmt)
                    fmt_b:   cmt.data[i] = {{24{moved[7]}}, moved[7:0]};
                    fmt_h:   cmt.data[i] = {{16{moved[15]}}, moved[15:0]};
                    fmt_bu:  cmt.data[i] = {24'h0, moved[7:0]};
                    fmt_hu:  cmt.data[i] = {16'h0, moved[15:0]};
                    default: cmt.data[i] = word;
                endcase
            end
        end
    endfunction

    task automatic compare_field(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED: %s got %0h expected %0h", name, got, exp);
            check_errors++;
        end
    endtask

    task automatic check_request(input mem_req_t exp);
        compare_field($sformatf("mem_req.rw uuid %0h", exp.tag.uuid),
                      128'(mem_req.rw), 128'(exp.rw));
        compare_field($sformatf("mem_req.mask uuid %0h", exp.tag.uuid),
                      128'(mem_req.mask), 128'(exp.mask));
        compare_field($sformatf("mem_req.tag uuid %0h", exp.tag.uuid),
                      128'(mem_req.tag), 128'(exp.tag));
        for (int i = 0; i < num_lanes; i++) begin
            if (exp.mask[i]) begin
                compare_field($sformatf("mem_req.addr[%0d]", i), 128'(mem_req.addr[i]),
                              128'(exp.addr[i]));
                compare_field($sformatf("mem_req.byteen[%0d]", i), 128'(mem_req.byteen[i]),
                              128'(exp.byteen[i]));
                if (exp.rw) begin
                    compare_field($sformatf("mem_req.data[%0d]", i), 128'(mem_req.data[i]),
                                  128'(exp.data[i]));
                end
            end
        end
    endtask

    // commits come back in any order, so match them by uuid
    task automatic check_commit();
        commit_t exp;
        logic    store;
        assert (expected.exists(commit.uuid)) else begin
            $display("commit for uuid %0h, which is not outstanding", commit.uuid);
            other_errors++;
        end
        if (expected.exists(commit.uuid)) begin
            exp = expected[commit.uuid];
            store = expected_store[commit.uuid];
            compare_field("commit.wid", 128'(commit.wid), 128'(exp.wid));
            compare_field("commit.tmask", 128'(commit.tmask), 128'(exp.tmask));
            compare_field("commit.pc", 128'(commit.pc), 128'(exp.pc));
            compare_field("commit.wb", 128'(commit.wb), 128'(exp.wb));
            compare_field("commit.rd", 128'(commit.rd), 128'(exp.rd));
            for (int i = 0; i < num_lanes; i++) begin
                if (exp.tmask[i] || store) begin
                    compare_field($sformatf("commit.data[%0d] uuid %0h", i, commit.uuid),
                                  128'(commit.data[i]), 128'(exp.data[i]));
                end
            end
            expected.delete(commit.uuid);
            expected_store.delete(commit.uuid);
        end
        commits++;
    endtask

    task automatic report_counts();
        $display({"errors: value %0d, protocol %0d, drain %0d; ",
                  "accepted %0d, committed %0d, stores %0d"},
                 check_errors, other_errors, drain_errors, accepted, commits, stores_seen);
    endtask

    always @(posedge clk) begin : monitor
        mem_req_t exp_req;
        commit_t  exp_cmt;
        mem_rsp_t load_rsp;
        int       idx;
        cycle++;
        if (cycle >= timeout_cycles) begin
            $display("timeout after %0d cycles with %0d commits", cycle, commits);
            report_counts();
            $display("TEST FAILED");
            $finish;
        end else if (!reset) begin
            if (after_reset) begin
                after_reset = 1'b0;
                assert (!commit_valid && !mem_req_valid) else begin
                    $display("commit or memory request valid right after reset");
                    other_errors++;
                end
            end
            assert ((exec_valid && exec_ready) == (mem_req_valid && mem_req_ready)) else begin
                $display("execute and memory request handshakes disagree");
                other_errors++;
            end
            if (exec_valid && exec_ready) begin
                expected_results(exec_data, exp_req, exp_cmt);
                check_request(exp_req);
                expected[exec_data.uuid] = exp_cmt;
                expected_store[exec_data.uuid] = exec_data.is_store;
                accepted++;
                if (mem_req.rw) begin
                    stores_seen++;
                end else begin
                    load_rsp.mask = mem_req.mask;
                    load_rsp.tag = mem_req.tag;
                    for (int i = 0; i < num_lanes; i++) begin
                        load_rsp.data[i] = mem_word(mem_req.addr[i]);
                    end
                    pend_rsp.push_back(load_rsp);
                    pend_due.push_back(cycle + $urandom_range(24, 2));
                end
            end
            if (mem_rsp_valid && mem_rsp_ready) next_rsp_valid = 1'b0;
            // any due load may go next, which reorders responses
            if (!next_rsp_valid && pend_rsp.size() > 0) begin
                idx = $urandom_range(pend_rsp.size() - 1, 0);
                if (pend_due[idx] <= cycle) begin
                    next_rsp = pend_rsp[idx];
                    next_rsp_valid = 1'b1;
                    pend_rsp.delete(idx);
                    pend_due.delete(idx);
                end
            end
            if (commit_valid && commit_ready) check_commit();
            next_req_ready = ($urandom_range(3, 0) != 0);
            // long commit stalls now and then to fill both buffers
            if (cycle % 300 < 40) next_commit_ready = ($urandom_range(7, 0) == 0);
            else next_commit_ready = ($urandom_range(2, 0) != 0);
        end
    end

    always @(negedge clk) begin
        mem_req_ready = next_req_ready;
        commit_ready  = next_commit_ready;
        mem_rsp_valid = next_rsp_valid;
        mem_rsp       = next_rsp;
    end

    initial begin
        reset = 1'b1;
        exec_valid = 1'b0;
        exec_data = '0;
        void'($urandom(32'he5b8912e));
        build_stimulus();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        for (int n = 0; n < num_instr; n++) begin
            exec_data = stim[n];
            exec_valid = 1'b1;
            @(posedge clk);
            while (!exec_ready) @(posedge clk);
            @(negedge clk);
            exec_valid = 1'b0;
            if ($urandom_range(3, 0) == 0) repeat ($urandom_range(3, 1)) @(negedge clk);
        end
        wait (commits >= num_instr);
        repeat (20) @(posedge clk);
        assert (expected.size() == 0 && accepted == num_instr && pend_rsp.size() == 0) else begin
            $display("%0d instructions still outstanding at the end", expected.size());
            drain_errors++;
        end
        report_counts();
        if (check_errors + other_errors + drain_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
design/lsu_isa_pkg.sv
design/lsu_pkg.sv
design/lsu_req_format.sv
design/lsu_rsp_format.sv
design/lsu_elastic_buf.sv
design/lsu_commit_arb.sv
design/lsu_slice.sv
verif/lsu_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= lsu_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
